//--- signal_pkg.sv
`default_nettype none

// sample level types shared by the dds, the detectors and the meter
package signal_pkg;

  localparam int sample_w = 14;                   // adc and dac word
  typedef logic signed [sample_w-1:0] sample_t;

  localparam int tuning_w = 32;
  typedef logic [tuning_w-1:0] tuning_t;          // dds phase step per clock

  // triangle bits with sign, dac peaks at 2047
  // leaves room for adc gains up to 4 in a 14 bit word
  localparam int dds_amplitude_w = 12;

  typedef struct packed {
    sample_t a;                                   // across dut plus shunt
    sample_t b;                                   // across shunt only
  } adc_pair_t;

  typedef logic signed [31:0] wide_t;             // amplitudes and quotients

endpackage

`default_nettype wire

//--- sweep_pkg.sv
`default_nettype none

// sweep sequencing types and the records passed along the result path
package sweep_pkg;

  localparam int index_w = 8;                     // 256 table entries
  typedef logic [index_w-1:0] index_t;

  typedef enum logic [2:0] {
    idle,
    load,                                         // one cycle for the table read
    settle,
    measure,
    finish
  } sweep_state_t;

  typedef enum logic [1:0] {
    wait_edge,
    window,
    lag
  } meter_state_t;

  typedef struct packed {
    logic                en;
    index_t              addr;
    signal_pkg::tuning_t data;
  } table_wr_t;

  typedef struct packed {
    index_t            index;
    signal_pkg::wide_t pp_a;                      // peak to peak of channel a
    signal_pkg::wide_t pp_b;
    logic [15:0]       lag;                       // clocks from a edge to b edge
  } meas_t;

  typedef struct packed {
    index_t            index;
    signal_pkg::wide_t magnitude;
    logic [15:0]       phase;
  } result_t;

endpackage

`default_nettype wire

//--- freq_table.sv
`timescale 1ns/1ps
`default_nettype none

module freq_table (
  input  wire logic                 clk125,
  input  wire sweep_pkg::table_wr_t table_wr,
  input  wire sweep_pkg::index_t    index,
  output signal_pkg::tuning_t       freq_word
);
  import signal_pkg::*;
  import sweep_pkg::*;

  // one tuning word per sweep point
  tuning_t ram [2**index_w] = '{default: '0};     // starts cleared

  always_ff @(posedge clk125)
  begin
    if (table_wr.en)
      ram[table_wr.addr] <= table_wr.data;        // host write port
    freq_word <= ram[index];                      // sweep read, one cycle late
  end

endmodule

`default_nettype wire

//--- dds_triangle.sv
`timescale 1ns/1ps
`default_nettype none

module dds_triangle (
  input  wire logic                clk125,
  input  wire logic                areset_n,
  input  wire signal_pkg::tuning_t freq_word,
  output signal_pkg::sample_t      dac_sample
);
  import signal_pkg::*;

  localparam int ramp_w = dds_amplitude_w - 1;    // rise within one quarter

  tuning_t                    phase;
  logic [ramp_w-1:0]          ramp;
  logic [dds_amplitude_w-1:0] mag;
  sample_t                    tri_val;

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      phase <= '0;
    else
      phase <= phase + freq_word;                 // wraps once per output period
  end

  // two msbs are the quadrant, the bits below them the ramp
  assign ramp = phase[tuning_w-3 -: ramp_w];

  // fold so quarters 1 and 3 fall back toward zero
  assign mag = {1'b0, phase[tuning_w-2] ? ~ramp : ramp};

  // msb set means the negative half
  assign tri_val = phase[tuning_w-1] ? -sample_t'(mag) : sample_t'(mag);

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      dac_sample <= '0;
    else
      dac_sample <= tri_val;                      // registered dac word
  end

endmodule

`default_nettype wire

//--- zero_cross_detector.sv
`timescale 1ns/1ps
`default_nettype none

module zero_cross_detector #(
  parameter int detector_width = 10
) (
  input  wire logic                clk125,
  input  wire logic                areset_n,
  input  wire signal_pkg::sample_t sample,
  output logic                     crossing
);
  localparam int run_w = $clog2(detector_width + 1);

  typedef enum logic [1:0] {hunt, count_neg, armed} det_state_t;

  det_state_t       state;
  logic [run_w-1:0] run;                          // consecutive negative samples
  logic             neg;

  assign neg = sample < 0;                        // sign only

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state    <= hunt;
      run      <= '0;
      crossing <= 1'b0;
    end
    else
    begin
      crossing <= 1'b0;
      case (state)
        hunt:
          if (neg)
          begin
            run   <= run_w'(1);
            state <= count_neg;
          end
        count_neg:
          if (!neg)
            state <= hunt;                        // run too short, chatter
          else if (run == run_w'(detector_width - 1))
            state <= armed;                       // this sample completes the run
          else
            run <= run + 1'b1;
        armed:
          if (!neg)
          begin
            crossing <= 1'b1;                     // first non negative sample
            state    <= hunt;
          end
        default:
          state <= hunt;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- sweep_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_controller #(
  parameter int num_points    = 8,
  parameter int settle_cycles = 2
) (
  input  wire logic         clk125,
  input  wire logic         areset_n,
  input  wire logic         start,
  input  wire logic         ref_crossing,
  input  wire logic         meas_done,
  output sweep_pkg::index_t index,
  output logic              meas_start,
  output logic              done
);
  import sweep_pkg::*;

  localparam int settle_w     = $clog2(settle_cycles + 1);
  localparam int drain_cycles = 34;               // divider latency for the last point
  localparam int drain_w      = $clog2(drain_cycles + 1);

  sweep_state_t        state;
  logic [settle_w-1:0] settle_count;              // reference periods seen
  logic [drain_w-1:0]  drain_count;

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state        <= idle;
      index        <= '0;
      settle_count <= '0;
      drain_count  <= '0;
      meas_start   <= 1'b0;
      done         <= 1'b0;
    end
    else
    begin
      meas_start <= 1'b0;                         // strobe
      case (state)
        idle:
          if (start)
            state <= load;
        load:
        begin
          settle_count <= '0;                     // table word lands this cycle
          state        <= settle;
        end
        settle:
          if (ref_crossing)
          begin
            if (settle_count == settle_w'(settle_cycles - 1))
            begin
              meas_start <= 1'b1;
              state      <= measure;
            end
            else
              settle_count <= settle_count + 1'b1;
          end
        measure:
          if (meas_done)
          begin
            if (index == index_t'(num_points - 1))
            begin
              drain_count <= '0;
              state       <= finish;
            end
            else
            begin
              index <= index + 1'b1;              // next point, reread table
              state <= load;
            end
          end
        finish:
        begin
          if (!done)
          begin
            if (drain_count == drain_w'(drain_cycles - 1))
              done <= 1'b1;                       // last result is out
            else
              drain_count <= drain_count + 1'b1;
          end
          else if (!start)
          begin
            done  <= 1'b0;                        // level handshake complete
            index <= '0;
            state <= idle;
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- gain_phase_meter.sv
`timescale 1ns/1ps
`default_nettype none

module gain_phase_meter #(
  parameter int meas_cycles = 4
) (
  input  wire logic                  clk125,
  input  wire logic                  areset_n,
  input  wire signal_pkg::adc_pair_t adc,
  input  wire logic                  crossing_a,
  input  wire logic                  crossing_b,
  input  wire logic                  meas_start,
  input  wire sweep_pkg::index_t     index,
  output logic                       meas_done,
  output sweep_pkg::meas_t           meas
);
  import signal_pkg::*;
  import sweep_pkg::*;

  localparam int period_w = $clog2(meas_cycles + 1);

  meter_state_t        state;
  logic                armed;                     // waiting for the opening a edge
  logic [period_w-1:0] periods;
  logic [15:0]         lag_count;
  index_t              point;                     // index latched at meas_start
  adc_pair_t           adc_q;
  sample_t             max_a;
  sample_t             min_a;
  sample_t             max_b;
  sample_t             min_b;

  // register lines up each sample with its crossing pulse
  always_ff @(posedge clk125)
    adc_q <= adc;

  // peak tracking
  always_ff @(posedge clk125)
  begin
    if (state == wait_edge)
    begin
      max_a <= adc_q.a;                           // seeds from the opening sample
      min_a <= adc_q.a;
      max_b <= adc_q.b;
      min_b <= adc_q.b;
    end
    else if (state == window)
    begin
      if (adc_q.a > max_a)
        max_a <= adc_q.a;
      if (adc_q.a < min_a)
        min_a <= adc_q.a;
      if (adc_q.b > max_b)
        max_b <= adc_q.b;
      if (adc_q.b < min_b)
        min_b <= adc_q.b;
    end
  end

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state     <= wait_edge;
      armed     <= 1'b0;
      periods   <= '0;
      lag_count <= '0;
      point     <= '0;
      meas_done <= 1'b0;
    end
    else
    begin
      meas_done <= 1'b0;
      case (state)
        wait_edge:
          if (meas_start)
          begin
            armed <= 1'b1;
            point <= index;
          end
          else if (armed && crossing_a)
          begin
            armed   <= 1'b0;
            periods <= '0;
            state   <= window;                    // window opens on this edge
          end
        window:
          if (crossing_a)
          begin
            if (periods == period_w'(meas_cycles - 1))
            begin
              lag_count <= 16'd1;                 // closing edge is clock one
              state     <= lag;
            end
            else
              periods <= periods + 1'b1;
          end
        lag:
          if (crossing_b)
          begin
            meas_done <= 1'b1;
            state     <= wait_edge;
          end
          else
            lag_count <= lag_count + 1'b1;
        default:
          state <= wait_edge;
      endcase
    end
  end

  // result record, updated with meas_done
  always_ff @(posedge clk125)
  begin
    if (state == lag && crossing_b)
    begin
      meas.index <= point;
      meas.pp_a  <= wide_t'(max_a) - wide_t'(min_a);
      meas.pp_b  <= wide_t'(max_b) - wide_t'(min_b);
      meas.lag   <= lag_count;
    end
  end

endmodule

`default_nettype wire

//--- ratio_divider.sv
`timescale 1ns/1ps
`default_nettype none

module ratio_divider #(
  parameter int shunt = 1000
) (
  input  wire logic             clk125,
  input  wire logic             areset_n,
  input  wire logic             div_start,
  input  wire sweep_pkg::meas_t meas,
  output logic                  result_valid,
  output sweep_pkg::result_t    result
);
  import signal_pkg::*;
  import sweep_pkg::*;

  logic        busy;
  logic [5:0]  step;                              // 32 shift steps then output
  logic [31:0] quo;                               // dividend out, quotient in
  logic [32:0] rem;
  logic [31:0] den;
  logic [32:0] rem_shift;
  logic [32:0] diff;
  index_t      point;
  logic [15:0] lag_q;

  assign rem_shift = {rem[31:0], quo[31]};
  assign diff      = rem_shift - {1'b0, den};     // msb set means it did not fit

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      busy         <= 1'b0;
      step         <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= 1'b0;
      if (!busy)
      begin
        if (div_start)
        begin
          busy <= 1'b1;
          step <= '0;
        end
      end
      else if (step == 6'd32)
      begin
        busy         <= 1'b0;
        result_valid <= 1'b1;
      end
      else
        step <= step + 1'b1;
    end
  end

  always_ff @(posedge clk125)
  begin
    if (!busy && div_start)
    begin
      quo   <= meas.pp_a * shunt;                 // scale before dividing
      rem   <= '0;
      den   <= meas.pp_b;
      point <= meas.index;
      lag_q <= meas.lag;
    end
    else if (busy && step != 6'd32)
    begin
      if (diff[32])
      begin
        rem <= rem_shift;                         // restore
        quo <= {quo[30:0], 1'b0};
      end
      else
      begin
        rem <= diff;
        quo <= {quo[30:0], 1'b1};
      end
    end
    else if (busy)
    begin
      result.index     <= point;
      result.magnitude <= wide_t'(quo) - wide_t'(shunt);  // drop the shunt share
      result.phase     <= lag_q;
    end
  end

endmodule

`default_nettype wire

//--- impedance_analyzer.sv
`timescale 1ns/1ps
`default_nettype none

module impedance_analyzer #(
  parameter int num_points     = 8,
  parameter int meas_cycles    = 4,
  parameter int settle_cycles  = 2,
  parameter int detector_width = 10,
  parameter int shunt          = 1000
) (
  input  wire logic                  clk125,
  input  wire logic                  areset_n,
  input  wire logic                  start,
  input  wire sweep_pkg::table_wr_t  table_wr,
  input  wire signal_pkg::adc_pair_t adc,
  output signal_pkg::sample_t        dac_sample,
  output signal_pkg::tuning_t        freq_word,
  output logic                       done,
  output logic                       result_valid,
  output sweep_pkg::result_t         result
);
  import sweep_pkg::*;

  index_t index;                                  // current sweep point
  logic   ref_crossing;
  logic   crossing_a;
  logic   crossing_b;
  logic   meas_start;
  logic   meas_done;                              // also starts the divider
  meas_t  meas;

  freq_table i_freq_table (
    .clk125    (clk125),
    .table_wr  (table_wr),
    .index     (index),
    .freq_word (freq_word)
  );

  dds_triangle i_dds_triangle (
    .clk125     (clk125),
    .areset_n   (areset_n),
    .freq_word  (freq_word),
    .dac_sample (dac_sample)
  );

  zero_cross_detector #(.detector_width(detector_width)) i_detector_ref (
    .clk125   (clk125),
    .areset_n (areset_n),
    .sample   (dac_sample),
    .crossing (ref_crossing)
  );

  zero_cross_detector #(.detector_width(detector_width)) i_detector_a (
    .clk125   (clk125),
    .areset_n (areset_n),
    .sample   (adc.a),
    .crossing (crossing_a)
  );

  zero_cross_detector #(.detector_width(detector_width)) i_detector_b (
    .clk125   (clk125),
    .areset_n (areset_n),
    .sample   (adc.b),
    .crossing (crossing_b)
  );

  sweep_controller #(
    .num_points    (num_points),
    .settle_cycles (settle_cycles)
  ) i_sweep_controller (
    .clk125       (clk125),
    .areset_n     (areset_n),
    .start        (start),
    .ref_crossing (ref_crossing),
    .meas_done    (meas_done),
    .index        (index),
    .meas_start   (meas_start),
    .done         (done)
  );

  gain_phase_meter #(.meas_cycles(meas_cycles)) i_gain_phase_meter (
    .clk125     (clk125),
    .areset_n   (areset_n),
    .adc        (adc),
    .crossing_a (crossing_a),
    .crossing_b (crossing_b),
    .meas_start (meas_start),
    .index      (index),
    .meas_done  (meas_done),
    .meas       (meas)
  );

  ratio_divider #(.shunt(shunt)) i_ratio_divider (
    .clk125       (clk125),
    .areset_n     (areset_n),
    .div_start    (meas_done),
    .meas         (meas),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

//--- impedance_analyzer_checker.sv
`timescale 1ns/1ps
`default_nettype none

module impedance_analyzer_checker #(
  parameter int num_points = 8
) (
  input wire logic                clk125,
  input wire logic                areset_n,
  input wire logic                done,
  input wire logic                result_valid,
  input wire sweep_pkg::result_t  result,
  input wire signal_pkg::tuning_t freq_word,
  input wire logic                meas_start,
  input wire logic                meas_done
);
  import sweep_pkg::*;

  int   failures = 0;                             // read by the testbench monitor
  logic measuring;                                // between meas_start and meas_done

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
      measuring <= 1'b0;
    else if (meas_start)
      measuring <= 1'b1;
    else if (meas_done)
      measuring <= 1'b0;
  end

  // single cycle divider strobe 34 clocks after its meas_done start
  valid_one_cycle: assert property (@(posedge clk125) disable iff (!areset_n)
    result_valid |-> $past(meas_done, 34) && !$past(result_valid))
  else
  begin
    $error("result_valid is not a one cycle strobe 34 cycles after meas_done");
    failures++;
  end

  // done follows the divider output of the last point by one cycle
  done_after_last: assert property (@(posedge clk125) disable iff (!areset_n)
    $rose(done) |-> $past(result_valid) && result.index == index_t'(num_points - 1))
  else
  begin
    $error("done rose without the last point result");
    failures++;
  end

  word_stable: assert property (@(posedge clk125) disable iff (!areset_n)
    measuring |-> $stable(freq_word))
  else
  begin
    $error("freq_word changed during a measurement");
    failures++;
  end

  index_range: assert property (@(posedge clk125) disable iff (!areset_n)
    result_valid |-> result.index < index_t'(num_points))
  else
  begin
    $error("result.index outside the sweep");
    failures++;
  end

endmodule

bind impedance_analyzer impedance_analyzer_checker #(.num_points(num_points)) i_checker (
  .clk125       (clk125),
  .areset_n     (areset_n),
  .done         (done),
  .result_valid (result_valid),
  .result       (result),
  .freq_word    (freq_word),
  .meas_start   (meas_start),
  .meas_done    (meas_done)
);

`default_nettype wire

//--- tb_impedance_analyzer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_impedance_analyzer;
  import signal_pkg::*;
  import sweep_pkg::*;

  localparam int num_points      = 8;             // dut defaults
  localparam int meas_cycles     = 4;
  localparam int settle_cycles   = 2;
  localparam int shunt           = 1000;
  localparam int num_sweeps      = 2;
  localparam int point_cycles    = (settle_cycles + meas_cycles + 3) * 256;  // slowest point
  localparam int watchdog_cycles = 2 * num_sweeps * num_points * point_cycles;

  logic      clk125;
  logic      areset_n;
  logic      start;
  table_wr_t table_wr;
  adc_pair_t adc;
  sample_t   dac_sample;
  tuning_t   freq_word;
  logic      done;
  logic      result_valid;
  result_t   result;

  logic [31:0] lfsr = 32'h5536_3736;
  tuning_t     table_model [num_points];          // words written this sweep
  int          gain  = 1;
  int          delay = 1;
  sample_t     dly [16] = '{default: '0};         // dac history, dly[0] newest

  impedance_analyzer i_impedance_analyzer (
    .clk125       (clk125),
    .areset_n     (areset_n),
    .start        (start),
    .table_wr     (table_wr),
    .adc          (adc),
    .dac_sample   (dac_sample),
    .freq_word    (freq_word),
    .done         (done),
    .result_valid (result_valid),
    .result       (result)
  );

  initial
  begin
    clk125 = 1'b0;
    forever #50 clk125 = ~clk125;
  end

  // network model: a is g times the stimulus, b trails by d clocks
  initial
  begin
    adc = '0;
    forever
    begin
      @(negedge clk125);
      for (int i = 15; i > 0; i--)
        dly[i] = dly[i-1];
      dly[0] = dac_sample;
      adc.a  = sample_t'(gain * int'(dly[0]));    // 4 x 2047 still fits
      adc.b  = dly[delay];
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  task automatic draw_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};             // one step per bit
    end
  endtask

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %0b, expected %0b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_tuning(input string name, input tuning_t got, input tuning_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_index(input string name, input index_t got, input index_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_wide(input string name, input wide_t got, input wide_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_phase(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // leaves the caller on the negedge where result_valid is high
  task automatic wait_result(input int point);
    int cycles;
    cycles = 0;
    @(negedge clk125);                            // step past the previous strobe
    while (result_valid !== 1'b1)
    begin
      if (cycles == point_cycles)
      begin
        $display("no result for point %0d within %0d cycles", point, point_cycles);
        stop_run();
      end
      else
      begin
        @(negedge clk125);
        cycles++;
      end
    end
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (done !== 1'b1)
    begin
      if (cycles == 64)
      begin
        $display("done did not rise after the last result");
        stop_run();
      end
      else
      begin
        @(negedge clk125);
        cycles++;
      end
    end
  endtask

  task automatic run_sweep();
    logic [31:0] v;
    int          next;
    draw_bits(2, v);
    gain = int'(v) + 1;                           // 1 to 4
    draw_bits(3, v);
    delay = int'(v) + 1;                          // 1 to 8 clocks
    for (int i = 0; i < num_points; i++)
    begin
      draw_bits(26, v);
      table_model[i] = tuning_t'(32'h0100_0000 + v % 32'h0300_0001);  // 256 down to 64 clocks
      table_wr.en    = 1'b1;
      table_wr.addr  = index_t'(i);
      table_wr.data  = table_model[i];
      @(negedge clk125);
    end
    table_wr = '0;
    start    = 1'b1;
    @(negedge clk125);
    check_tuning("freq_word", freq_word, table_model[0]);
    for (int p = 0; p < num_points; p++)
    begin
      wait_result(p);
      next = (p < num_points - 1) ? p + 1 : p;    // controller already moved on
      check_bit("done", done, 1'b0);
      check_index("result.index", result.index, index_t'(p));
      check_wide("result.magnitude", result.magnitude, wide_t'((gain - 1) * shunt));
      check_phase("result.phase", result.phase, 16'(delay));
      check_tuning("freq_word", freq_word, table_model[next]);
    end
    wait_done();
    repeat (8)
    begin
      @(negedge clk125);
      check_bit("done", done, 1'b1);              // held while start is high
      check_bit("result_valid", result_valid, 1'b0);
    end
    start = 1'b0;
    @(negedge clk125);
    check_bit("done", done, 1'b0);
  endtask

  // assertion failures in the bound checker end the run here
  always @(negedge clk125)
  begin
    if (i_impedance_analyzer.i_checker.failures != 0)
    begin
      $display("protocol assertion failed in the bound checker");
      stop_run();
    end
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk125);
    $display("watchdog expired after %0d cycles, sweeps did not complete", watchdog_cycles);
    stop_run();
  end

  initial
  begin
    areset_n = 1'b0;
    start    = 1'b0;
    table_wr = '0;
    repeat (16) @(negedge clk125);
    areset_n = 1'b1;
    @(negedge clk125);
    check_bit("done", done, 1'b0);
    check_bit("result_valid", result_valid, 1'b0);
    check_sample("dac_sample", dac_sample, '0);   // table still zero
    repeat (num_sweeps) run_sweep();              // second pass rewrites the table
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- impedance_analyzer.f
signal_pkg.sv
sweep_pkg.sv
freq_table.sv
dds_triangle.sv
zero_cross_detector.sv
sweep_controller.sv
gain_phase_meter.sv
ratio_divider.sv
impedance_analyzer.sv
impedance_analyzer_checker.sv
tb_impedance_analyzer.sv

//--- Makefile
TOP = tb_impedance_analyzer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f impedance_analyzer.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
